//--- include/lim_settings.svh
`ifndef LIM_SETTINGS_SVH
`define LIM_SETTINGS_SVH

// ====================
// word and address sizes
`define LIM_DATA_W      32          // data word
`define LIM_ADDR_W      10          // byte address
`define LIM_WORD_AW     8           // word index
`define LIM_DEPTH       256         // words in the array
`define LIM_BE_W        4           // one enable per byte

// ====================
// function cell layout
`define LIM_FUNCT_ADDR  10'h3FC     // last word of the map
`define LIM_OP_LSB      0           // operation code field
`define LIM_SIZE_LSB    8           // range size field
`define LIM_SIZE_W      8           // range size in words

`endif

//--- src/lim_pkg.sv
package lim_pkg;

    // operation held in the function cell, unknown codes act as none
    typedef enum logic [7:0] {
        LIM_OP_NONE = 8'd0,
        LIM_OP_AND  = 8'd1,
        LIM_OP_OR   = 8'd2,
        LIM_OP_XOR  = 8'd3
    } lim_op_e;

    // decoded request class
    typedef enum logic [1:0] {
        CMD_LOAD,
        CMD_STORE,
        CMD_PROGRAM     // store to the function cell
    } lim_kind_e;

    // range sequencer in the array
    typedef enum logic {SEQ_IDLE, SEQ_RANGE} lim_seq_e;

endpackage

//--- src/lim_cmd_if.sv
`timescale 1ns/1ps
`include "lim_settings.svh"

interface lim_cmd_if;
    import lim_pkg::*;

    logic                    valid;   // command present
    logic                    ready;   // array takes it this cycle
    lim_kind_e               kind;
    logic [`LIM_WORD_AW-1:0] idx;     // first word touched
    logic [`LIM_DATA_W-1:0]  wdata;   // store data / mask, cell copy on loads
    logic [`LIM_BE_W-1:0]    be;      // only used by plain stores
    lim_op_e                 op;      // already normalised by the decoder
    logic [`LIM_SIZE_W-1:0]  count;   // words written, 1 unless range op

    // decoder side
    modport src (
        output valid, kind, idx, wdata, be, op, count,
        input  ready
    );

    // array side
    modport dst (
        input  valid, kind, idx, wdata, be, op, count,
        output ready
    );

endinterface

//--- src/lim_cmd_decoder.sv
`timescale 1ns/1ps
`include "lim_settings.svh"

module lim_cmd_decoder (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    input  logic [`LIM_ADDR_W-1:0] req_addr_i,
    input  logic                   req_we_i,
    input  logic [`LIM_BE_W-1:0]   req_be_i,
    input  logic [`LIM_DATA_W-1:0] req_wdata_i,
    lim_cmd_if.src                 cmd
);
    import lim_pkg::*;

    localparam logic [`LIM_ADDR_W-1:0] FUNCT_ADDR = `LIM_FUNCT_ADDR;

    logic [`LIM_DATA_W-1:0]      funct_q;     // function cell
    logic                        accept;
    logic                        is_funct;
    lim_kind_e                   kind_d;
    logic [$bits(lim_op_e)-1:0]  op_code;     // raw op field
    lim_op_e                     cell_op;
    logic [`LIM_SIZE_W-1:0]      cell_size;
    logic [`LIM_SIZE_W-1:0]      count_d;

    // ====================
    // request side
    assign req_ready_o = !cmd.valid || cmd.ready;   // slot frees as it drains
    assign accept      = req_valid_i && req_ready_o;
    assign is_funct    = req_addr_i[`LIM_ADDR_W-1:2] == FUNCT_ADDR[`LIM_ADDR_W-1:2];

    always_comb begin
        if (!req_we_i) begin
            kind_d = CMD_LOAD;
        end else if (is_funct) begin
            kind_d = CMD_PROGRAM;   // reprogram the cell
        end else begin
            kind_d = CMD_STORE;
        end
    end

    // ====================
    // function cell fields
    assign op_code   = funct_q[`LIM_OP_LSB +: $bits(lim_op_e)];
    assign cell_size = funct_q[`LIM_SIZE_LSB +: `LIM_SIZE_W];

    always_comb begin
        case (op_code)
            LIM_OP_AND, LIM_OP_OR, LIM_OP_XOR: cell_op = lim_op_e'(op_code);
            default:                           cell_op = LIM_OP_NONE; // unknown code
        endcase
    end

    // range only for op stores of 2+ words
    always_comb begin
        count_d = `LIM_SIZE_W'(1);
        if (kind_d == CMD_STORE && cell_op != LIM_OP_NONE && cell_size > `LIM_SIZE_W'(1)) begin
            count_d = cell_size;
        end
    end

    // updated at acceptance so the next request sees it
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            funct_q <= '0;
        end else if (accept && kind_d == CMD_PROGRAM) begin
            funct_q <= req_wdata_i;     // whole word, enables not applied
        end
    end

    // ====================
    // command register
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cmd.valid <= 1'b0;
        end else if (accept) begin
            cmd.valid <= 1'b1;
        end else if (cmd.ready) begin
            cmd.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            cmd.kind  <= kind_d;
            cmd.idx   <= req_addr_i[`LIM_ADDR_W-1:2];   // drop byte offset
            cmd.wdata <= (kind_d == CMD_LOAD) ? funct_q : req_wdata_i;
            cmd.be    <= req_be_i;
            cmd.op    <= cell_op;
            cmd.count <= count_d;
        end
    end

endmodule

//--- src/lim_logic_array.sv
`timescale 1ns/1ps
`include "lim_settings.svh"

module lim_logic_array (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    lim_cmd_if.dst                 cmd,
    output logic                   res_valid_o,
    input  logic                   res_ready_i,
    output logic [`LIM_DATA_W-1:0] res_data_o
);
    import lim_pkg::*;

    localparam logic [`LIM_ADDR_W-1:0] FUNCT_ADDR = `LIM_FUNCT_ADDR;

    logic [`LIM_DATA_W-1:0]  mem [`LIM_DEPTH];   // word array

    lim_seq_e                seq_q;
    logic [`LIM_SIZE_W-1:0]  cnt_q;       // words still to write
    logic [`LIM_WORD_AW-1:0] idx_q;       // next word of the range
    logic [`LIM_DATA_W-1:0]  mask_q;      // same mask for every word
    lim_op_e                 op_q;

    logic                    res_free;
    logic                    cmd_fire;
    logic                    last_step;
    logic                    range_step;
    logic                    wr_en;
    logic                    done;
    logic [`LIM_WORD_AW-1:0] cur_idx;
    logic [`LIM_DATA_W-1:0]  cur_mask;
    logic [`LIM_BE_W-1:0]    cur_be;
    lim_op_e                 cur_op;
    logic [`LIM_DATA_W-1:0]  old_word;
    logic [`LIM_DATA_W-1:0]  new_word;
    logic [`LIM_DATA_W-1:0]  res_d;

    // write-back value for one word
    function automatic logic [`LIM_DATA_W-1:0] apply_op(
        input logic [`LIM_DATA_W-1:0] old_w,
        input logic [`LIM_DATA_W-1:0] data_w,
        input logic [`LIM_BE_W-1:0]   be,
        input lim_op_e                op
    );
        logic [`LIM_DATA_W-1:0] merged;
        merged = old_w;
        for (int b = 0; b < `LIM_BE_W; b++) begin
            if (be[b]) begin
                merged[8*b +: 8] = data_w[8*b +: 8];
            end
        end
        case (op)
            LIM_OP_AND: return old_w & data_w;
            LIM_OP_OR:  return old_w | data_w;
            LIM_OP_XOR: return old_w ^ data_w;
            default:    return merged;          // plain byte store
        endcase
    endfunction

    // ====================
    // handshake
    assign res_free   = !res_valid_o || res_ready_i;
    assign cmd.ready  = (seq_q == SEQ_IDLE) && res_free;
    assign cmd_fire   = cmd.valid && cmd.ready;
    assign last_step  = cnt_q == `LIM_SIZE_W'(1);
    // last range word waits for a free result slot
    assign range_step = (seq_q == SEQ_RANGE) && (!last_step || res_free);

    // ====================
    // datapath
    assign cur_idx  = (seq_q == SEQ_RANGE) ? idx_q  : cmd.idx;
    assign cur_mask = (seq_q == SEQ_RANGE) ? mask_q : cmd.wdata;
    assign cur_op   = (seq_q == SEQ_RANGE) ? op_q   : cmd.op;
    assign cur_be   = (seq_q == SEQ_RANGE) ? {`LIM_BE_W{1'b1}} : cmd.be;

    assign old_word = mem[cur_idx];
    assign new_word = apply_op(old_word, cur_mask, cur_be, cur_op);

    assign wr_en = range_step || (cmd_fire && cmd.kind == CMD_STORE);
    assign done  = (range_step && last_step) || (cmd_fire && cmd.count == `LIM_SIZE_W'(1));

    always_comb begin
        if (seq_q == SEQ_RANGE) begin
            res_d = new_word;           // last word of the range
        end else begin
            case (cmd.kind)
                CMD_LOAD:    res_d = (cmd.idx == FUNCT_ADDR[`LIM_ADDR_W-1:2]) ?
                                     cmd.wdata : old_word;  // cell copy
                CMD_PROGRAM: res_d = cmd.wdata;             // echo cell value
                default:     res_d = new_word;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[cur_idx] <= new_word;
        end
    end

    // ====================
    // range sequencer
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            seq_q <= SEQ_IDLE;
            cnt_q <= '0;
        end else if (cmd_fire && cmd.count > `LIM_SIZE_W'(1)) begin
            seq_q <= SEQ_RANGE;                         // first word written now
            cnt_q <= cmd.count - `LIM_SIZE_W'(1);
        end else if (range_step) begin
            cnt_q <= cnt_q - `LIM_SIZE_W'(1);
            if (last_step) begin
                seq_q <= SEQ_IDLE;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_fire) begin
            idx_q  <= cmd.idx + `LIM_WORD_AW'(1);       // wraps modulo depth
            mask_q <= cmd.wdata;
            op_q   <= cmd.op;
        end else if (range_step) begin
            idx_q  <= idx_q + `LIM_WORD_AW'(1);
        end
    end

    // ====================
    // result register
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            res_valid_o <= 1'b0;
        end else if (done) begin
            res_valid_o <= 1'b1;
        end else if (res_ready_i) begin
            res_valid_o <= 1'b0;    // taken by the buffer
        end
    end

    always_ff @(posedge clk_i) begin
        if (done) begin
            res_data_o <= res_d;
        end
    end

endmodule

//--- src/lim_resp_buffer.sv
`timescale 1ns/1ps
`include "lim_settings.svh"

module lim_resp_buffer (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   res_valid_i,
    output logic                   res_ready_o,
    input  logic [`LIM_DATA_W-1:0] res_data_i,
    output logic                   resp_valid_o,
    input  logic                   resp_ready_i,
    output logic [`LIM_DATA_W-1:0] resp_rdata_o
);

    logic load;     // new entry this cycle

    // refill on the cycle the entry drains
    assign res_ready_o = !resp_valid_o || resp_ready_i;
    assign load        = res_valid_i && res_ready_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            resp_valid_o <= 1'b0;
        end else if (load) begin
            resp_valid_o <= 1'b1;
        end else if (resp_ready_i) begin
            resp_valid_o <= 1'b0;   // drained, nothing behind it
        end
    end

    // held stable while stalled
    always_ff @(posedge clk_i) begin
        if (load) begin
            resp_rdata_o <= res_data_i;
        end
    end

endmodule

//--- src/lim_ram_top.sv
`timescale 1ns/1ps
`include "lim_settings.svh"

module lim_ram_top (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // request port
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    input  logic [`LIM_ADDR_W-1:0] req_addr_i,
    input  logic                   req_we_i,
    input  logic [`LIM_BE_W-1:0]   req_be_i,
    input  logic [`LIM_DATA_W-1:0] req_wdata_i,
    // response port
    output logic                   resp_valid_o,
    input  logic                   resp_ready_i,
    output logic [`LIM_DATA_W-1:0] resp_rdata_o
);

    logic                   res_valid;  // array to buffer
    logic                   res_ready;
    logic [`LIM_DATA_W-1:0] res_data;

    // ====================
    // decoder to array
    lim_cmd_if u_cmd_if ();

    lim_cmd_decoder u_decoder (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_addr_i  (req_addr_i),
        .req_we_i    (req_we_i),
        .req_be_i    (req_be_i),
        .req_wdata_i (req_wdata_i),
        .cmd         (u_cmd_if.src)
    );

    lim_logic_array u_array (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .cmd         (u_cmd_if.dst),
        .res_valid_o (res_valid),
        .res_ready_i (res_ready),
        .res_data_o  (res_data)
    );

    // ====================
    // output slice
    lim_resp_buffer u_resp_buffer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .res_valid_i  (res_valid),
        .res_ready_o  (res_ready),
        .res_data_i   (res_data),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .resp_rdata_o (resp_rdata_o)
    );

endmodule

//--- sim/tb_lim_ram.sv
`timescale 1ns/1ps
`include "lim_settings.svh"

module tb_lim_ram;

    localparam int REQ_TIMEOUT   = 200;     // cycles for one request to be taken
    localparam int DRAIN_TIMEOUT = 4000;    // cycles for the last responses
    localparam logic [`LIM_WORD_AW-1:0] CELL_WORD = `LIM_WORD_AW'(`LIM_FUNCT_ADDR >> 2);

    logic                   clk_i;
    logic                   rst_ni;
    logic                   req_valid_i;
    logic                   req_ready_o;
    logic [`LIM_ADDR_W-1:0] req_addr_i;
    logic                   req_we_i;
    logic [`LIM_BE_W-1:0]   req_be_i;
    logic [`LIM_DATA_W-1:0] req_wdata_i;
    logic                   resp_valid_o;
    logic                   resp_ready_i;
    logic [`LIM_DATA_W-1:0] resp_rdata_o;

    // reference state
    logic [`LIM_DATA_W-1:0] model_mem [`LIM_DEPTH];
    logic [`LIM_DATA_W-1:0] model_cell;
    logic [`LIM_DATA_W-1:0] exp_q [$];     // expected responses in request order
    int                     req_count;
    int                     resp_count;

    lim_ram_top uut (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_addr_i   (req_addr_i),
        .req_we_i     (req_we_i),
        .req_be_i     (req_be_i),
        .req_wdata_i  (req_wdata_i),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .resp_rdata_o (resp_rdata_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;      // 4 ns period
    end

    // ====================
    // reference model
    function automatic logic [`LIM_DATA_W-1:0] expected_resp(
        input logic [`LIM_ADDR_W-1:0] addr,
        input logic                   we,
        input logic [`LIM_BE_W-1:0]   be,
        input logic [`LIM_DATA_W-1:0] wdata
    );
        logic [`LIM_WORD_AW-1:0] word;
        logic [7:0]              op;
        logic [`LIM_SIZE_W-1:0]  size;
        int                      n;
        logic [`LIM_DATA_W-1:0]  w;
        word = addr[`LIM_ADDR_W-1:2];
        op   = model_cell[`LIM_OP_LSB +: 8];
        size = model_cell[`LIM_SIZE_LSB +: `LIM_SIZE_W];
        w    = '0;
        if (!we) begin
            return (word == CELL_WORD) ? model_cell : model_mem[word];   // raw word
        end
        if (word == CELL_WORD) begin
            model_cell = wdata;     // enables ignored for the cell
            return wdata;
        end
        n = 1;
        if (op >= 8'd1 && op <= 8'd3 && size >= 8'd2) begin
            n = int'(size);         // range only under a real op
        end
        for (int i = 0; i < n; i++) begin
            w = model_mem[word];
            case (op)
                8'd1: w = w & wdata;
                8'd2: w = w | wdata;
                8'd3: w = w ^ wdata;
                default: begin
                    // plain byte merge
                    for (int b = 0; b < `LIM_BE_W; b++) begin
                        if (be[b]) begin
                            w[8*b +: 8] = wdata[8*b +: 8];
                        end
                    end
                end
            endcase
            model_mem[word] = w;
            word = word + `LIM_WORD_AW'(1);     // wraps at the depth
        end
        return w;                   // last word written
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1, "stopped at %0t ns", $time);
    endtask

    // random byte offset that the DUT drops
    function automatic logic [`LIM_ADDR_W-1:0] word_addr(input logic [`LIM_WORD_AW-1:0] w);
        return {w, 2'($urandom)};
    endfunction

    // ====================
    // request driver for use right after a rising edge
    task automatic send_req(
        input logic [`LIM_ADDR_W-1:0] addr,
        input logic                   we,
        input logic [`LIM_BE_W-1:0]   be,
        input logic [`LIM_DATA_W-1:0] wdata
    );
        int   waited;
        logic taken;
        exp_q.push_back(expected_resp(addr, we, be, wdata));
        req_count++;
        req_valid_i <= 1'b1;
        req_addr_i  <= addr;
        req_we_i    <= we;
        req_be_i    <= be;
        req_wdata_i <= wdata;
        waited = 0;
        taken  = 1'b0;
        while (!taken) begin
            @(negedge clk_i);
            taken = req_ready_o;        // stable mid cycle
            @(posedge clk_i);
            waited++;
            if (waited > REQ_TIMEOUT) begin
                abort_run($sformatf("timeout: request to %h never accepted", addr));
            end
        end
    endtask

    // program the cell and read it back
    task automatic program_cell(input logic [`LIM_DATA_W-1:0] value);
        send_req(`LIM_FUNCT_ADDR, 1'b1, `LIM_BE_W'($urandom), value);
        send_req(`LIM_FUNCT_ADDR, 1'b0, '0, '0);
    endtask

    // one range store followed by a load of each word in it
    task automatic range_store_check(input logic [`LIM_WORD_AW-1:0] start, input int size);
        send_req(word_addr(start), 1'b1, `LIM_BE_W'($urandom), $urandom);
        for (int k = 0; k < size; k++) begin
            send_req(word_addr(start + `LIM_WORD_AW'(k)), 1'b0, '0, '0);
        end
    endtask

    // ====================
    // response side
    initial begin : ready_drive
        resp_ready_i = 1'b0;
        forever begin
            @(posedge clk_i);
            resp_ready_i <= ($urandom_range(3) != 0);   // random withholding
        end
    end

    initial begin : compare
        logic [`LIM_DATA_W-1:0] exp_word;
        resp_count = 0;
        forever begin
            @(negedge clk_i);
            if (rst_ni && resp_valid_o && resp_ready_i) begin   // transfer at next edge
                assert (exp_q.size() != 0)
                    else abort_run("response arrived with no request outstanding");
                exp_word = exp_q.pop_front();
                assert (resp_rdata_o === exp_word) else begin
                    $display("** Error at %0t ns: resp_rdata_o = %h, expected %h",
                             $time, resp_rdata_o, exp_word);
                    abort_run("response data mismatch");
                end
                resp_count++;
            end
        end
    end

    // ====================
    // stimulus
    initial begin : stimulus
        logic [`LIM_WORD_AW-1:0] w;
        int                      waited;
        rst_ni      = 1'b0;
        req_valid_i = 1'b0;
        req_addr_i  = '0;
        req_we_i    = 1'b0;
        req_be_i    = '0;
        req_wdata_i = '0;
        model_cell  = '0;
        req_count   = 0;
        void'($urandom(32'h5de1_3bba));
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        assert (req_ready_o && !resp_valid_o)
            else abort_run("state after reset wrong, request not ready or response pending");
        @(posedge clk_i);

        // fill every data word but the cell word
        for (int i = 0; i < `LIM_DEPTH - 1; i++) begin
            send_req(word_addr(`LIM_WORD_AW'(i)), 1'b1, 4'hF, $urandom);
        end
        // plain stores under random enables
        for (int i = 0; i < 40; i++) begin
            w = `LIM_WORD_AW'($urandom_range(254));
            send_req(word_addr(w), 1'b1, `LIM_BE_W'($urandom), $urandom);
            send_req(word_addr(w), 1'b0, '0, '0);
        end
        // AND, OR, XOR on single words
        for (int code = 1; code <= 3; code++) begin
            program_cell({16'h0, 8'h00, 8'(code)});
            for (int i = 0; i < 8; i++) begin
                w = `LIM_WORD_AW'($urandom_range(254));
                send_req(word_addr(w), 1'b1, `LIM_BE_W'($urandom), $urandom);
                send_req(word_addr(w), 1'b0, '0, '0);
            end
        end
        // ranges of 2 to 6 words
        for (int size = 2; size <= 6; size++) begin
            program_cell({16'h0, 8'(size), 8'($urandom_range(3, 1))});
            range_store_check(`LIM_WORD_AW'($urandom_range(200)), size);
            if (size >= 3) begin
                range_store_check(`LIM_WORD_AW'(257 - size), size);   // wraps to word 0
            end
        end
        // unknown op code and op none act as plain stores
        program_cell({16'h0, 8'h04, 8'h7C});
        range_store_check(`LIM_WORD_AW'($urandom_range(200)), 2);
        program_cell({16'h0, 8'h05, 8'h00});
        range_store_check(`LIM_WORD_AW'($urandom_range(200)), 2);
        program_cell($urandom);
        program_cell('0);

        // ====================
        // mixed back-to-back traffic with ranges kept clear of the cell word
        for (int i = 0; i < 200; i++) begin
            case ($urandom_range(9))
                0: program_cell({16'h0, 8'($urandom_range(6)), 8'($urandom_range(3))});
                1, 2, 3, 4: send_req(word_addr(`LIM_WORD_AW'($urandom_range(248))), 1'b1,
                                     `LIM_BE_W'($urandom), $urandom);
                default: send_req(word_addr(`LIM_WORD_AW'($urandom_range(255))), 1'b0, '0, '0);
            endcase
        end
        req_valid_i <= 1'b0;

        waited = 0;
        while (resp_count < req_count) begin
            @(posedge clk_i);
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                abort_run("timeout: responses still missing at end of run");
            end
        end
        repeat (10) @(posedge clk_i);   // room for a stray extra response
        $display("sim passed");
        $finish;
    end

endmodule

//--- src.f
+incdir+include
src/lim_pkg.sv
src/lim_cmd_if.sv
src/lim_cmd_decoder.sv
src/lim_logic_array.sv
src/lim_resp_buffer.sv
src/lim_ram_top.sv
sim/tb_lim_ram.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_lim_ram \
		-f src.f -o Vtb_lim_ram
	./obj_dir/Vtb_lim_ram

clean:
	rm -rf obj_dir
